// File: tb/backendPatterns.mem
// Columns: instruction word _ expected destination value
// Word fields: opcode 31:28, immB 27, tagDst 26:22, tagA 21:17, tagB 16:12, imm 11:0
02822000_00000003
02D43000_00000006
13164000_00000002
43587000_00000005
6B800FFF_FFFFFFFF
0BDA07F0_000007F5
7416F000_00002FBE
245C9000_00000009
5CA20004_00000090
74E02000_00005F7C
35245000_00000095
1D660FFE_00005F7E
75A95000_00379456
05EC8000_0037945E
062E1000_0037945F
76465000_0000000F
46B19000_00379450
6EC00123_00000123
57364000_00001230
77799000_000110D0
2FB400F0_00000050
37FBE000_000110D0
71BDB000_00005AF0
100DF000_FFFF4A20

// File: backendTop.f
+incdir+hdl
hdl/backendPkg.sv
hdl/uopDecode.sv
hdl/issueQueue.sv
hdl/intExecute.sv
hdl/resultWriteback.sv
hdl/backendTop.sv
tb/backend_props.sv
tb/backendTb.sv

// File: Bender.yml
package:
  name: backend

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/backendPkg.sv
      - hdl/uopDecode.sv
      - hdl/issueQueue.sv
      - hdl/intExecute.sv
      - hdl/resultWriteback.sv
      - hdl/backendTop.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/backend_props.sv
      - tb/backendTb.sv

// File: tb/backendTb.sv
`include "backend_params.svh"

module backendTb;

    localparam int NUM_PATTERNS = 24;
    // First pattern sent under the long stall
    localparam int FIRST_STALL = 14;
    localparam int HOLD_CYCLES = 20;
    localparam int WATCHDOG_CYCLES = NUM_PATTERNS * 20 + 200;
    localparam int NUM_SQN = 2**`BE_SQN_BITS;
    localparam int NUM_TAGS = 2**`BE_TAG_BITS;

    logic clk;
    logic rst;
    logic instrValid;
    logic [31:0] instr;
    logic stall;
    logic full;
    backendPkg::Result_t result;

    // Instruction word in 63:32, expected destination value in 31:0
    logic [63:0] patterns [NUM_PATTERNS];

    logic [31:0] expValue [NUM_SQN];
    logic [`BE_TAG_BITS-1:0] expTag [NUM_SQN];
    bit seen [NUM_SQN];

    int nextPattern;
    int sentCount;
    int resultCount;
    int stallLeft;
    bit sentLast;
    bit fullObserved;

    backendTop i_backendTop (
        .clk        (clk),
        .rst        (rst),
        .instrValid (instrValid),
        .instr      (instr),
        .stall      (stall),
        .full       (full),
        .result     (result)
    );

    always #2 clk = ~clk;

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            $display("Test failed");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic stopWithError(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "Run aborted");
    endtask

    // One clock of stimulus with full sampled mid-cycle
    task automatic driveCycle(input bit allowSend, input bit randomStall);
        bit canSend;
        @(negedge clk);
        fullObserved = full;
        // At most every other cycle, so full already counts the last send
        canSend = allowSend && !full && !sentLast && nextPattern < NUM_PATTERNS;
        @(posedge clk);
        if (randomStall) begin
            if (stallLeft > 0) begin
                stallLeft--;
                stall <= 1'b1;
            end else if ($urandom_range(5) == 0) begin
                stallLeft = $urandom_range(5, 1);
                stall <= 1'b1;
            end else begin
                stall <= 1'b0;
            end
        end
        if (canSend) begin
            instrValid <= 1'b1;
            instr <= patterns[nextPattern][63:32];
            expValue[sentCount] = patterns[nextPattern][31:0];
            // tagDst sits in word bits 26:22
            expTag[sentCount] = patterns[nextPattern][58:54];
            sentCount++;
            nextPattern++;
            sentLast = 1'b1;
        end else begin
            instrValid <= 1'b0;
            sentLast = 1'b0;
        end
    endtask

    task automatic idleInputs();
        @(posedge clk);
        instrValid <= 1'b0;
        stall <= 1'b0;
        sentLast = 1'b0;
        stallLeft = 0;
    endtask

    task automatic waitForResults();
        while (resultCount < sentCount) begin
            @(posedge clk);
        end
    endtask

    // Result monitor
    always @(negedge clk) begin
        if (!rst && result.valid) begin
            if (result.sqN >= sentCount || seen[result.sqN]) begin
                stopWithError($sformatf("Unexpected or repeated result for sqN %0d",
                                        result.sqN));
            end
            checkValue($sformatf("tag of sqN %0d", result.sqN),
                       32'(expTag[result.sqN]), 32'(result.tagDst));
            checkValue($sformatf("value of sqN %0d", result.sqN),
                       expValue[result.sqN], result.value);
            seen[result.sqN] = 1'b1;
            resultCount++;
        end
    end

    initial begin
        int resultsBefore;
        logic [31:0] lastExp [NUM_TAGS];
        bit written [NUM_TAGS];
        logic [`BE_TAG_BITS-1:0] tag;

        void'($urandom(16157));
        clk = 1'b0;
        rst = 1'b1;
        instrValid = 1'b0;
        instr = '0;
        stall = 1'b0;
        nextPattern = 0;
        sentCount = 0;
        resultCount = 0;
        stallLeft = 0;
        sentLast = 1'b0;
        fullObserved = 1'b0;

        $readmemh("tb/backendPatterns.mem", patterns);
        if ($isunknown(patterns[NUM_PATTERNS-1])) begin
            stopWithError("Pattern file is missing or has too few lines");
        end

        repeat (16) @(posedge clk);
        rst <= 1'b0;

        // Dependent chains, immediates and multiplies under random stalls
        while (nextPattern < FIRST_STALL) begin
            driveCycle(1'b1, 1'b1);
        end
        idleInputs();
        waitForResults();

        // Long stall that fills the queue
        @(posedge clk);
        stall <= 1'b1;
        do begin
            driveCycle(1'b1, 1'b0);
        end while (!fullObserved);
        checkValue("entries queued when full", `BE_IQ_SIZE, sentCount - FIRST_STALL);

        @(posedge clk);
        resultsBefore = resultCount;
        repeat (HOLD_CYCLES) @(posedge clk);
        checkValue("results during stall", resultsBefore, resultCount);
        stall <= 1'b0;

        // Remaining patterns after the stall drains
        while (nextPattern < NUM_PATTERNS) begin
            driveCycle(1'b1, 1'b1);
        end
        idleInputs();
        waitForResults();

        checkValue("results received", NUM_PATTERNS, resultCount);

        // Final value of each tag in program order
        for (int i = 0; i < NUM_TAGS; i++) begin
            written[i] = 1'b0;
        end
        for (int i = 0; i < NUM_PATTERNS; i++) begin
            tag = patterns[i][58:54];
            lastExp[tag] = patterns[i][31:0];
            written[tag] = 1'b1;
        end
        for (int i = 0; i < NUM_TAGS; i++) begin
            if (written[i]) begin
                checkValue($sformatf("final value of tag %0d", i), lastExp[i],
                           i_backendTop.i_resultWriteback.regFile[i]);
            end else begin
                // Untouched registers keep their reset value
                checkValue($sformatf("final value of tag %0d", i), 32'(i),
                           i_backendTop.i_resultWriteback.regFile[i]);
            end
        end

        $display("Test completed successfully");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $fatal(1, "Watchdog expired");
    end

endmodule

// File: tb/backend_props.sv
module backendProps (
    input logic                clk,
    input logic                rst,
    input logic                instrValid,
    input logic                stall,
    input logic                full,
    input backendPkg::Uop_t    dispUop,
    input backendPkg::Uop_t    issueUop,
    input backendPkg::Result_t aluRes,
    input backendPkg::Result_t mulRes,
    input backendPkg::Result_t result
);

    // Shared result bus, one producer at a time
    singleProducer: assert property (@(posedge clk) disable iff (rst)
        !(aluRes.valid && mulRes.valid))
        else $error("ALU and multiplier results valid together");

    noIssueInStall: assert property (@(posedge clk) disable iff (rst)
        stall |=> !issueUop.valid)
        else $error("Micro-op issued during stall");

    noDispatchWhenFull: assert property (@(posedge clk) disable iff (rst)
        instrValid |-> !full)
        else $error("Instruction sent while queue full");

    quietAfterReset: assert property (@(posedge clk)
        $fell(rst) |-> !issueUop.valid && !dispUop.valid && !result.valid && !full)
        else $error("Outputs active right after reset");

endmodule

bind backendTop backendProps i_backendProps (
    .clk        (clk),
    .rst        (rst),
    .instrValid (instrValid),
    .stall      (stall),
    .full       (full),
    .dispUop    (dispUop),
    .issueUop   (issueUop),
    .aluRes     (aluRes),
    .mulRes     (mulRes),
    .result     (result)
);

// File: hdl/backendTop.sv
`include "backend_params.svh"

module backendTop (
    input  logic                clk,
    input  logic                rst,
    input  logic                instrValid,
    input  logic [31:0]         instr,
    input  logic                stall,
    output logic                full,
    output backendPkg::Result_t result
);

    backendPkg::Uop_t dispUop;
    backendPkg::Uop_t issueUop;
    backendPkg::Result_t aluRes;
    backendPkg::Result_t mulRes;
    logic [`BE_TAG_BITS-1:0] rdTagA;
    logic [`BE_TAG_BITS-1:0] rdTagB;
    logic [`BE_DATA_BITS-1:0] rdDataA;
    logic [`BE_DATA_BITS-1:0] rdDataB;

    uopDecode i_uopDecode (
        .clk        (clk),
        .rst        (rst),
        .instrValid (instrValid),
        .instr      (instr),
        .result     (result),
        .dispUop    (dispUop)
    );

    issueQueue #(
        .SIZE (`BE_IQ_SIZE)
    ) i_issueQueue (
        .clk      (clk),
        .rst      (rst),
        .stall    (stall),
        .dispUop  (dispUop),
        .result   (result),
        .issueUop (issueUop),
        .full     (full)
    );

    intExecute i_intExecute (
        .clk      (clk),
        .rst      (rst),
        .issueUop (issueUop),
        .rdTagA   (rdTagA),
        .rdTagB   (rdTagB),
        .rdDataA  (rdDataA),
        .rdDataB  (rdDataB),
        .aluRes   (aluRes),
        .mulRes   (mulRes)
    );

    resultWriteback i_resultWriteback (
        .clk     (clk),
        .rst     (rst),
        .aluRes  (aluRes),
        .mulRes  (mulRes),
        .rdTagA  (rdTagA),
        .rdTagB  (rdTagB),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB),
        .result  (result)
    );

endmodule

// File: hdl/resultWriteback.sv
`include "backend_params.svh"

module resultWriteback (
    input  logic                     clk,
    input  logic                     rst,
    input  backendPkg::Result_t      aluRes,
    input  backendPkg::Result_t      mulRes,
    input  logic [`BE_TAG_BITS-1:0]  rdTagA,
    input  logic [`BE_TAG_BITS-1:0]  rdTagB,
    output logic [`BE_DATA_BITS-1:0] rdDataA,
    output logic [`BE_DATA_BITS-1:0] rdDataB,
    output backendPkg::Result_t      result
);

    logic [`BE_DATA_BITS-1:0] regFile [2**`BE_TAG_BITS];
    backendPkg::Result_t wrRes;

    // The queue keeps the two producers apart, at most one is valid
    assign wrRes = aluRes.valid ? aluRes : mulRes;

    always_ff @(posedge clk) begin
        if (rst) begin
            // Register i starts out holding i
            for (int i = 0; i < 2**`BE_TAG_BITS; i++) begin
                regFile[i] <= `BE_DATA_BITS'(i);
            end
            result.valid <= 1'b0;
        end else begin
            result <= wrRes;
            if (wrRes.valid) begin
                regFile[wrRes.tagDst] <= wrRes.value;
            end
        end
    end

    // Read ports see the value written at the coming edge
    assign rdDataA = (wrRes.valid && wrRes.tagDst == rdTagA) ? wrRes.value
                                                             : regFile[rdTagA];
    assign rdDataB = (wrRes.valid && wrRes.tagDst == rdTagB) ? wrRes.value
                                                             : regFile[rdTagB];

endmodule

// File: hdl/intExecute.sv
`include "backend_params.svh"

module intExecute (
    input  logic                     clk,
    input  logic                     rst,
    input  backendPkg::Uop_t         issueUop,
    output logic [`BE_TAG_BITS-1:0]  rdTagA,
    output logic [`BE_TAG_BITS-1:0]  rdTagB,
    input  logic [`BE_DATA_BITS-1:0] rdDataA,
    input  logic [`BE_DATA_BITS-1:0] rdDataB,
    output backendPkg::Result_t      aluRes,
    output backendPkg::Result_t      mulRes
);

    logic [`BE_DATA_BITS-1:0] immExt;
    logic [`BE_DATA_BITS-1:0] opB;
    logic [`BE_DATA_BITS-1:0] aluValue;

    // One multiply per stage, stage 0 holds the product
    backendPkg::Result_t mulPipe [`BE_MUL_LAT];

    assign rdTagA = issueUop.tagA;
    assign rdTagB = issueUop.tagB;

    assign immExt = {{(`BE_DATA_BITS - 12){issueUop.imm[11]}}, issueUop.imm};
    assign opB = issueUop.immB ? immExt : rdDataB;

    always_comb begin
        case (issueUop.opcode)
            backendPkg::OP_ADD: aluValue = rdDataA + opB;
            backendPkg::OP_SUB: aluValue = rdDataA - opB;
            backendPkg::OP_AND: aluValue = rdDataA & opB;
            backendPkg::OP_OR:  aluValue = rdDataA | opB;
            backendPkg::OP_XOR: aluValue = rdDataA ^ opB;
            backendPkg::OP_SLL: aluValue = rdDataA << opB[4:0];
            backendPkg::OP_LI:  aluValue = immExt;
            default:            aluValue = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            aluRes.valid <= 1'b0;
        end else begin
            aluRes.valid <= issueUop.valid && issueUop.fu == backendPkg::FU_ALU;
            aluRes.tagDst <= issueUop.tagDst;
            aluRes.sqN <= issueUop.sqN;
            aluRes.value <= aluValue;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `BE_MUL_LAT; i++) begin
                mulPipe[i].valid <= 1'b0;
            end
        end else begin
            mulPipe[0].valid <= issueUop.valid && issueUop.fu == backendPkg::FU_MUL;
            mulPipe[0].tagDst <= issueUop.tagDst;
            mulPipe[0].sqN <= issueUop.sqN;
            // Low half of the product only
            mulPipe[0].value <= rdDataA * opB;
            for (int i = 1; i < `BE_MUL_LAT; i++) begin
                mulPipe[i] <= mulPipe[i - 1];
            end
        end
    end

    assign mulRes = mulPipe[`BE_MUL_LAT-1];

endmodule

// File: hdl/issueQueue.sv
`include "backend_params.svh"

module issueQueue #(
    parameter int SIZE = `BE_IQ_SIZE
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                stall,
    input  backendPkg::Uop_t    dispUop,
    input  backendPkg::Result_t result,
    output backendPkg::Uop_t    issueUop,
    output logic                full
);

    localparam int IDX_BITS = $clog2(SIZE);

    // Entry 0 is the oldest, valid entries are 0 .. insertIndex-1
    backendPkg::Uop_t entries [SIZE];
    backendPkg::Uop_t woken [SIZE];
    backendPkg::Uop_t dispWoken;

    logic [IDX_BITS:0] insertIndex;
    logic [IDX_BITS-1:0] insPos;
    logic [IDX_BITS-1:0] selIdx;
    logic selValid;
    logic doIssue;
    logic mulIssue;

    // Bit 0 set means the result bus is taken by a multiply two cycles later
    logic [`BE_MUL_LAT-2:0] reservedWb;

    // Wakeup against the result bus
    always_comb begin
        for (int i = 0; i < SIZE; i++) begin
            woken[i] = entries[i];
            if (result.valid && entries[i].tagA == result.tagDst) begin
                woken[i].availA = 1'b1;
            end
            if (result.valid && entries[i].tagB == result.tagDst) begin
                woken[i].availB = 1'b1;
            end
        end

        // Operand may be broadcast while the micro-op waits in decode
        dispWoken = dispUop;
        if (result.valid && dispUop.tagA == result.tagDst) begin
            dispWoken.availA = 1'b1;
        end
        if (result.valid && dispUop.tagB == result.tagDst) begin
            dispWoken.availB = 1'b1;
        end
    end

    // Oldest ready entry
    always_comb begin
        selValid = 1'b0;
        selIdx = '0;
        for (int i = 0; i < SIZE; i++) begin
            if (!selValid && i < insertIndex && woken[i].availA && woken[i].availB &&
                !(woken[i].fu == backendPkg::FU_ALU && reservedWb[0])) begin
                selValid = 1'b1;
                selIdx = IDX_BITS'(i);
            end
        end
    end

    assign doIssue = selValid && !stall;
    assign mulIssue = doIssue && entries[selIdx].fu == backendPkg::FU_MUL;

    // Slot for the new entry after the collapse
    assign insPos = IDX_BITS'(insertIndex - {{IDX_BITS{1'b0}}, doIssue});

    // Leave room for the micro-op still sitting in decode
    assign full = (insertIndex + {{IDX_BITS{1'b0}}, dispUop.valid}) >= (IDX_BITS + 1)'(SIZE);

    always_ff @(posedge clk) begin
        if (rst) begin
            insertIndex <= '0;
            reservedWb <= '0;
            issueUop.valid <= 1'b0;
        end else begin
            issueUop <= woken[selIdx];
            issueUop.valid <= doIssue;

            // Shift toward bit 0, a new multiply enters at the top
            reservedWb <= {mulIssue, reservedWb[`BE_MUL_LAT-2:1]};

            insertIndex <= insertIndex + {{IDX_BITS{1'b0}}, dispUop.valid}
                           - {{IDX_BITS{1'b0}}, doIssue};
        end
    end

    // Entry storage with collapse on issue
    always_ff @(posedge clk) begin
        for (int i = 0; i < SIZE - 1; i++) begin
            // Younger entries move up and keep this cycle's wakeups
            entries[i] <= (doIssue && i >= selIdx) ? woken[i + 1] : woken[i];
        end
        entries[SIZE-1] <= woken[SIZE-1];

        if (dispUop.valid) begin
            entries[insPos] <= dispWoken;
        end
    end

endmodule

// File: hdl/uopDecode.sv
`include "backend_params.svh"

module uopDecode (
    input  logic                clk,
    input  logic                rst,
    input  logic                instrValid,
    input  logic [31:0]         instr,
    input  backendPkg::Result_t result,
    output backendPkg::Uop_t    dispUop
);

    backendPkg::InstrWord_t word;
    backendPkg::IntOp_t op;
    logic [2**`BE_TAG_BITS-1:0] ready;
    logic [`BE_SQN_BITS-1:0] sqN;
    logic availA;
    logic availB;

    assign word = backendPkg::InstrWord_t'(instr);

    // Unused encodings 8..15 fall back to add
    assign op = word.opcode[3] ? backendPkg::OP_ADD : backendPkg::IntOp_t'(word.opcode);

    always_comb begin
        // Scoreboard, or a result broadcast this very cycle
        availA = ready[word.tagA] || (result.valid && result.tagDst == word.tagA);
        availB = ready[word.tagB] || (result.valid && result.tagDst == word.tagB);

        // Load-immediate never reads tagA
        if (op == backendPkg::OP_LI) begin
            availA = 1'b1;
        end
        if (word.immB) begin
            availB = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ready <= '1;
            sqN <= '0;
            dispUop.valid <= 1'b0;
        end else begin
            dispUop.valid <= instrValid;

            if (instrValid) begin
                dispUop.sqN <= sqN;
                dispUop.opcode <= op;
                dispUop.fu <= (op == backendPkg::OP_MUL) ? backendPkg::FU_MUL
                                                         : backendPkg::FU_ALU;
                dispUop.tagA <= word.tagA;
                dispUop.tagB <= word.tagB;
                dispUop.tagDst <= word.tagDst;
                dispUop.availA <= availA;
                dispUop.availB <= availB;
                dispUop.immB <= word.immB;
                dispUop.imm <= word.imm;
                sqN <= sqN + 1'b1;
            end

            if (result.valid) begin
                ready[result.tagDst] <= 1'b1;
            end
            // A new writer is younger than the broadcast, so clearing wins
            if (instrValid) begin
                ready[word.tagDst] <= 1'b0;
            end
        end
    end

endmodule

// File: hdl/backendPkg.sv
`include "backend_params.svh"

package backendPkg;

    // Integer opcodes, encoded as in bits 31:28 of the instruction word
    typedef enum logic [3:0] {
        OP_ADD = 4'h0,
        OP_SUB = 4'h1,
        OP_AND = 4'h2,
        OP_OR  = 4'h3,
        OP_XOR = 4'h4,
        OP_SLL = 4'h5,
        OP_LI  = 4'h6,
        OP_MUL = 4'h7
    } IntOp_t;

    typedef enum logic {
        FU_ALU = 1'b0,
        FU_MUL = 1'b1
    } FuncUnit_t;

    // Instruction word, high to low
    // opcode 31:28, immB 27, tagDst 26:22, tagA 21:17, tagB 16:12, imm 11:0
    typedef struct packed {
        logic [3:0]              opcode;
        logic                    immB;
        logic [`BE_TAG_BITS-1:0] tagDst;
        logic [`BE_TAG_BITS-1:0] tagA;
        logic [`BE_TAG_BITS-1:0] tagB;
        logic [11:0]             imm;
    } InstrWord_t;

    typedef struct packed {
        logic                    valid;
        logic [`BE_SQN_BITS-1:0] sqN;
        IntOp_t                  opcode;
        FuncUnit_t               fu;
        logic [`BE_TAG_BITS-1:0] tagA;
        logic [`BE_TAG_BITS-1:0] tagB;
        logic [`BE_TAG_BITS-1:0] tagDst;
        logic                    availA;
        logic                    availB;
        // Operand B comes from imm instead of tagB
        logic                    immB;
        logic [11:0]             imm;
    } Uop_t;

    typedef struct packed {
        logic                     valid;
        logic [`BE_TAG_BITS-1:0]  tagDst;
        logic [`BE_SQN_BITS-1:0]  sqN;
        logic [`BE_DATA_BITS-1:0] value;
    } Result_t;

endpackage

// File: hdl/backend_params.svh
`ifndef BACKEND_PARAMS_SVH
`define BACKEND_PARAMS_SVH

// Physical register tag, 32 registers
`define BE_TAG_BITS 5
// Integer datapath width
`define BE_DATA_BITS 32
// Default issue queue depth
`define BE_IQ_SIZE 8
// Cycles from multiply issue to mulRes
`define BE_MUL_LAT 3
// Sequence number width
`define BE_SQN_BITS 6

`endif
